// ==== chip_top.f ====
+incdir+include
design/chip_pkg.sv
design/chip_ifs.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/cache.sv
design/chip_top.sv
testbench/tb_mem_model.sv
testbench/tb_chip_top.sv

// ==== design/cache.sv ====
// direct-mapped cache: 8 lines of 4 words, write-back and write-allocate when writable
`timescale 1ns/10ps
`default_nettype none
`include "chip_params.svh"

module cache #(
    parameter bit WRITABLE = 1'b1  // 0 strips the write and write-back paths
) (
    input  logic             clk,
    input  logic             rst_n,
    cache_if.responder       proc,
    output logic             mem_read,
    output logic             mem_write,
    output chip_pkg::baddr_t mem_addr,
    output chip_pkg::line_t  mem_wdata,
    input  chip_pkg::line_t  mem_rdata,
    input  logic             mem_ready
);
    import chip_pkg::*;

    localparam int IDX_W = $clog2(`LINE_NUM);

    line_t                data_q [0:`LINE_NUM-1];
    tag_t                 tag_q  [0:`LINE_NUM-1];
    logic [`LINE_NUM-1:0] valid_q;
    logic [`LINE_NUM-1:0] dirty_q;
    cache_state_t         state, state_nxt;

    tag_t             tag_in;
    logic [IDX_W-1:0] idx;
    logic [1:0]       offset;
    logic             wr, req, hit, victim_dirty;
    line_t            line, line_wr;

    assign {tag_in, idx, offset} = proc.addr;

    assign wr   = WRITABLE && proc.wen;
    assign req  = proc.ren || wr;
    assign line = data_q[idx];
    assign hit  = valid_q[idx] && (tag_q[idx] == tag_in);
    assign victim_dirty = WRITABLE && valid_q[idx] && dirty_q[idx];

    // done in the compare cycle that hits
    assign proc.stall = req && !(state == st_compare && hit);
    assign proc.rdata = line[offset*`WORD_W +: `WORD_W];

    always_comb begin
        line_wr = line;
        line_wr[offset*`WORD_W +: `WORD_W] = proc.wdata;  // merge store word
    end

    // ------------------------------
    // miss FSM
    // compare holds while requests keep hitting, so two caches waiting
    // on each other stay in step
    always_comb begin
        state_nxt = state;
        case (state)
            st_idle:      if (req) state_nxt = st_compare;
            st_compare: begin
                if (!req)              state_nxt = st_idle;
                else if (hit)          state_nxt = st_compare;
                else if (victim_dirty) state_nxt = st_writeback;
                else                   state_nxt = st_allocate;
            end
            st_allocate:  if (mem_ready) state_nxt = st_compare;
            st_writeback: if (mem_ready) state_nxt = st_allocate;
            default:      state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            mem_read  <= 1'b0;
            mem_write <= 1'b0;
            valid_q   <= '0;
            dirty_q   <= '0;
        end else begin
            state     <= state_nxt;
            mem_read  <= (state_nxt == st_allocate);  // held until mem_ready
            mem_write <= WRITABLE && (state_nxt == st_writeback);
            if (state == st_allocate && mem_ready) begin
                valid_q[idx] <= 1'b1;
                dirty_q[idx] <= 1'b0;
            end else if (state == st_compare && hit && wr) begin
                dirty_q[idx] <= 1'b1;
            end
        end
    end

    // ------------------------------
    // line storage and memory request payload
    always_ff @(posedge clk) begin
        if (state == st_allocate && mem_ready) begin
            data_q[idx] <= mem_rdata;  // refill
            tag_q[idx]  <= tag_in;
        end else if (state == st_compare && hit && wr) begin
            data_q[idx] <= line_wr;
        end
        if (WRITABLE && state_nxt == st_writeback) begin
            mem_addr <= {tag_q[idx], idx};  // victim block
        end else begin
            mem_addr <= {tag_in, idx};
        end
        mem_wdata <= WRITABLE ? line : '0;
    end

endmodule

`default_nettype wire

// ==== design/chip_ifs.sv ====
// pipeline interfaces: cache request bus and the ID/EX and EX/MEM stage registers
`timescale 1ns/10ps
`default_nettype none

// processor side of a cache
interface cache_if;
    import chip_pkg::*;

    logic   ren;
    logic   wen;
    waddr_t addr;
    word_t  wdata;
    word_t  rdata;
    logic   stall;  // combinational, high until the request is done

    modport requester (output ren, wen, addr, wdata, input rdata, stall);
    modport responder (input ren, wen, addr, wdata, output rdata, stall);
endinterface

interface id_ex_if;
    import chip_pkg::*;

    logic     reg_write, mem_to_reg, branch, mem_read, mem_write, reg_dst, alu_src;
    logic     [1:0] alu_class;
    waddr_t   pc;
    word_t    rdata1, rdata2, imm;
    reg_idx_t rt, rd;

    modport producer (output reg_write, mem_to_reg, branch, mem_read, mem_write,
                      reg_dst, alu_src, alu_class, pc, rdata1, rdata2, imm, rt, rd);
    modport consumer (input reg_write, mem_to_reg, branch, mem_read, mem_write,
                      reg_dst, alu_src, alu_class, pc, rdata1, rdata2, imm, rt, rd);
endinterface

interface ex_mem_if;
    import chip_pkg::*;

    logic     reg_write, mem_to_reg, branch, mem_read, mem_write;
    waddr_t   target;
    logic     zero;
    word_t    result, store_data;
    reg_idx_t dest;

    modport producer (output reg_write, mem_to_reg, branch, mem_read, mem_write,
                      target, zero, result, store_data, dest);
    modport consumer (input reg_write, mem_to_reg, branch, mem_read, mem_write,
                      target, zero, result, store_data, dest);
endinterface

`default_nettype wire

// ==== design/chip_pkg.sv ====
// chip package: vector types and state encodings shared by pipeline and caches
`default_nettype none
`include "chip_params.svh"

package chip_pkg;

    typedef logic [`WORD_W-1:0]  word_t;
    typedef logic [`WADDR_W-1:0] waddr_t;
    typedef logic [`BADDR_W-1:0] baddr_t;
    typedef logic [`LINE_W-1:0]  line_t;
    typedef logic [`TAG_W-1:0]   tag_t;
    typedef logic [4:0]          reg_idx_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt
    } alu_op_t;

    // cache miss handling
    typedef enum logic [1:0] {
        st_idle,
        st_compare,
        st_allocate,
        st_writeback
    } cache_state_t;

endpackage

`default_nettype wire

// ==== design/chip_top.sv ====
// chip top: four-stage-register MIPS pipeline with instruction and data caches
`timescale 1ns/10ps
`default_nettype none

module chip_top (
    input  logic             clk,
    input  logic             rst_n,
    // instruction memory
    output logic             mem_read_i,
    output logic             mem_write_i,
    output chip_pkg::baddr_t mem_addr_i,
    output chip_pkg::line_t  mem_wdata_i,
    input  chip_pkg::line_t  mem_rdata_i,
    input  logic             mem_ready_i,
    // data memory
    output logic             mem_read_d,
    output logic             mem_write_d,
    output chip_pkg::baddr_t mem_addr_d,
    output chip_pkg::line_t  mem_wdata_d,
    input  chip_pkg::line_t  mem_rdata_d,
    input  logic             mem_ready_d,
    // data-cache request, observed by the testbed
    output chip_pkg::waddr_t dcache_addr,
    output chip_pkg::word_t  dcache_wdata,
    output logic             dcache_wen
);
    import chip_pkg::*;

    cache_if  icache_bus ();
    cache_if  dcache_bus ();
    id_ex_if  id_ex ();
    ex_mem_if ex_mem ();

    logic     stall;
    logic     branch_taken;
    waddr_t   branch_target;
    waddr_t   if_pc;
    word_t    if_inst;
    logic     wb_wen;
    reg_idx_t wb_reg;
    word_t    wb_data;

    assign stall = icache_bus.stall | dcache_bus.stall;  // freezes every stage

    assign dcache_addr  = dcache_bus.addr;
    assign dcache_wdata = dcache_bus.wdata;
    assign dcache_wen   = dcache_bus.wen;

    // ------------------------------
    // pipeline
    fetch_stage u_fetch (
        .clk(clk), .rst_n(rst_n), .stall(stall),
        .branch_taken(branch_taken), .branch_target(branch_target),
        .icache(icache_bus), .if_pc(if_pc), .if_inst(if_inst)
    );

    decode_stage u_decode (
        .clk(clk), .rst_n(rst_n), .stall(stall), .if_pc(if_pc), .if_inst(if_inst),
        .wb_wen(wb_wen), .wb_reg(wb_reg), .wb_data(wb_data), .id_ex(id_ex)
    );

    execute_stage u_execute (
        .clk(clk), .rst_n(rst_n), .stall(stall), .id_ex(id_ex), .ex_mem(ex_mem)
    );

    memory_stage u_memory (
        .clk(clk), .rst_n(rst_n), .stall(stall), .ex_mem(ex_mem), .dcache(dcache_bus),
        .branch_taken(branch_taken), .branch_target(branch_target),
        .wb_wen(wb_wen), .wb_reg(wb_reg), .wb_data(wb_data)
    );

    // ------------------------------
    // caches
    cache #(.WRITABLE(1'b0)) i_cache (
        .clk(clk), .rst_n(rst_n), .proc(icache_bus),
        .mem_read(mem_read_i), .mem_write(mem_write_i), .mem_addr(mem_addr_i),
        .mem_wdata(mem_wdata_i), .mem_rdata(mem_rdata_i), .mem_ready(mem_ready_i)
    );

    cache #(.WRITABLE(1'b1)) d_cache (
        .clk(clk), .rst_n(rst_n), .proc(dcache_bus),
        .mem_read(mem_read_d), .mem_write(mem_write_d), .mem_addr(mem_addr_d),
        .mem_wdata(mem_wdata_d), .mem_rdata(mem_rdata_d), .mem_ready(mem_ready_d)
    );

endmodule

`default_nettype wire

// ==== design/decode_stage.sv ====
// decode stage: control decode, register file and ID/EX register
`timescale 1ns/10ps
`default_nettype none
`include "chip_params.svh"

module decode_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               stall,
    input  chip_pkg::waddr_t   if_pc,
    input  chip_pkg::word_t    if_inst,
    input  logic               wb_wen,
    input  chip_pkg::reg_idx_t wb_reg,
    input  chip_pkg::word_t    wb_data,
    id_ex_if.producer          id_ex
);
    import chip_pkg::*;

    word_t      regs [0:31];
    logic [5:0] opcode;
    reg_idx_t   rs, rt, rd;
    logic       reg_write, mem_to_reg, branch, mem_read, mem_write, reg_dst, alu_src;
    logic [1:0] alu_class;

    assign opcode = if_inst[31:26];
    assign rs     = if_inst[25:21];
    assign rt     = if_inst[20:16];
    assign rd     = if_inst[15:11];

    // ------------------------------
    // control decode
    always_comb begin
        {reg_write, mem_to_reg, branch, mem_read, mem_write, reg_dst, alu_src} = '0;
        alu_class = `ALUC_ADD;
        case (opcode)
            `OP_RTYPE: begin
                reg_write = 1'b1;
                reg_dst   = 1'b1;
                alu_class = `ALUC_FN;
            end
            `OP_LW: begin
                reg_write  = 1'b1;
                mem_to_reg = 1'b1;
                mem_read   = 1'b1;
                alu_src    = 1'b1;
            end
            `OP_SW: begin
                mem_write = 1'b1;
                alu_src   = 1'b1;
            end
            `OP_BEQ: begin
                branch    = 1'b1;
                alu_class = `ALUC_SUB;  // zero from rs - rt
            end
            default: ;  // everything else is a no-op
        endcase
    end

    // register file, no bypass from writeback
    always_ff @(posedge clk) begin
        if (!stall && wb_wen) begin
            regs[wb_reg] <= wb_data;
        end
    end

    // ------------------------------
    // ID/EX register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            {id_ex.reg_write, id_ex.mem_to_reg, id_ex.branch} <= '0;
            {id_ex.mem_read, id_ex.mem_write, id_ex.reg_dst, id_ex.alu_src} <= '0;
            id_ex.alu_class <= `ALUC_ADD;
        end else if (!stall) begin
            {id_ex.reg_write, id_ex.mem_to_reg, id_ex.branch} <= {reg_write, mem_to_reg, branch};
            {id_ex.mem_read, id_ex.mem_write} <= {mem_read, mem_write};
            {id_ex.reg_dst, id_ex.alu_src}    <= {reg_dst, alu_src};
            id_ex.alu_class <= alu_class;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            id_ex.pc     <= if_pc;
            id_ex.rdata1 <= (rs == '0) ? '0 : regs[rs];  // r0 reads zero
            id_ex.rdata2 <= (rt == '0) ? '0 : regs[rt];
            id_ex.imm    <= {{16{if_inst[15]}}, if_inst[15:0]};
            id_ex.rt     <= rt;
            id_ex.rd     <= rd;
        end
    end

endmodule

`default_nettype wire

// ==== design/execute_stage.sv ====
// execute stage: ALU control, ALU, branch target and EX/MEM register
`timescale 1ns/10ps
`default_nettype none
`include "chip_params.svh"

module execute_stage (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       stall,
    id_ex_if.consumer  id_ex,
    ex_mem_if.producer ex_mem
);
    import chip_pkg::*;

    alu_op_t alu_op;
    word_t   op_b;
    word_t   diff;
    word_t   result;

    // ------------------------------
    // ALU control
    always_comb begin
        case (id_ex.alu_class)
            `ALUC_ADD: alu_op = alu_add;  // lw / sw address
            `ALUC_SUB: alu_op = alu_sub;  // beq compare
            default: begin
                case (id_ex.imm[5:0])
                    `FN_ADD: alu_op = alu_add;
                    `FN_SUB: alu_op = alu_sub;
                    `FN_OR:  alu_op = alu_or;
                    `FN_SLT: alu_op = alu_slt;
                    default: alu_op = alu_and;  // FN_AND and unknown codes
                endcase
            end
        endcase
    end

    assign op_b = id_ex.alu_src ? id_ex.imm : id_ex.rdata2;
    assign diff = id_ex.rdata1 - op_b;

    always_comb begin
        case (alu_op)
            alu_add: result = id_ex.rdata1 + op_b;
            alu_sub: result = diff;
            alu_and: result = id_ex.rdata1 & op_b;
            alu_or:  result = id_ex.rdata1 | op_b;
            default: result = word_t'($signed(id_ex.rdata1) < $signed(op_b));  // slt
        endcase
    end

    // ------------------------------
    // EX/MEM register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            {ex_mem.reg_write, ex_mem.mem_to_reg, ex_mem.branch} <= '0;
            {ex_mem.mem_read, ex_mem.mem_write} <= '0;
        end else if (!stall) begin
            {ex_mem.reg_write, ex_mem.mem_to_reg} <= {id_ex.reg_write, id_ex.mem_to_reg};
            {ex_mem.branch, ex_mem.mem_read, ex_mem.mem_write} <=
                {id_ex.branch, id_ex.mem_read, id_ex.mem_write};
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ex_mem.target     <= id_ex.pc + 1'b1 + id_ex.imm[`WADDR_W-1:0];  // word units
            ex_mem.zero       <= (diff == '0);
            ex_mem.result     <= result;
            ex_mem.store_data <= id_ex.rdata2;
            ex_mem.dest       <= id_ex.reg_dst ? id_ex.rd : id_ex.rt;
        end
    end

endmodule

`default_nettype wire

// ==== design/fetch_stage.sv ====
// fetch stage: program counter, instruction-cache read and IF/ID register
`timescale 1ns/10ps
`default_nettype none

module fetch_stage (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             stall,
    input  logic             branch_taken,
    input  chip_pkg::waddr_t branch_target,
    cache_if.requester       icache,
    output chip_pkg::waddr_t if_pc,
    output chip_pkg::word_t  if_inst
);
    import chip_pkg::*;

    waddr_t pc;  // word address

    // always reading, read-only port
    assign icache.ren   = 1'b1;
    assign icache.wen   = 1'b0;
    assign icache.addr  = pc;
    assign icache.wdata = '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc      <= '0;
            if_pc   <= '0;
            if_inst <= '0;  // all-zero word behaves as a no-op
        end else if (!stall) begin
            pc      <= branch_taken ? branch_target : pc + 1'b1;
            if_pc   <= pc;
            if_inst <= icache.rdata;
        end
    end

endmodule

`default_nettype wire

// ==== design/memory_stage.sv ====
// memory stage: data-cache request, branch decision, MEM/WB register and writeback mux
`timescale 1ns/10ps
`default_nettype none
`include "chip_params.svh"

module memory_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               stall,
    ex_mem_if.consumer         ex_mem,
    cache_if.requester         dcache,
    output logic               branch_taken,
    output chip_pkg::waddr_t   branch_target,
    output logic               wb_wen,
    output chip_pkg::reg_idx_t wb_reg,
    output chip_pkg::word_t    wb_data
);
    import chip_pkg::*;

    logic  mw_reg_write, mw_mem_to_reg;
    word_t mw_load_data, mw_result;

    // data addresses are word addresses
    assign dcache.ren   = ex_mem.mem_read;
    assign dcache.wen   = ex_mem.mem_write;
    assign dcache.addr  = ex_mem.result[`WADDR_W-1:0];
    assign dcache.wdata = ex_mem.store_data;

    assign branch_taken  = ex_mem.branch & ex_mem.zero;
    assign branch_target = ex_mem.target;

    // MEM/WB register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mw_reg_write  <= 1'b0;
            mw_mem_to_reg <= 1'b0;
        end else if (!stall) begin
            mw_reg_write  <= ex_mem.reg_write;
            mw_mem_to_reg <= ex_mem.mem_to_reg;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            mw_load_data <= dcache.rdata;  // valid once the load is done
            mw_result    <= ex_mem.result;
            wb_reg       <= ex_mem.dest;
        end
    end

    assign wb_wen  = mw_reg_write;
    assign wb_data = mw_mem_to_reg ? mw_load_data : mw_result;

endmodule

`default_nettype wire

// ==== include/chip_params.svh ====
// chip parameters: data widths, cache geometry and instruction encodings
`ifndef CHIP_PARAMS_SVH
`define CHIP_PARAMS_SVH

// ------------------------------
// widths and cache geometry
`define WORD_W   32
`define WADDR_W  30  // word address
`define BADDR_W  28  // memory block address, 4 words per block
`define LINE_W   128
`define LINE_NUM 8
`define TAG_W    25

// ------------------------------
// opcodes and R-type function codes
`define OP_RTYPE 6'b000000
`define OP_LW    6'b100011
`define OP_SW    6'b101011
`define OP_BEQ   6'b000100
`define FN_ADD   6'b100000
`define FN_SUB   6'b100010
`define FN_AND   6'b100100
`define FN_OR    6'b100101
`define FN_SLT   6'b101010

// alu op class passed from decode to execute
`define ALUC_ADD 2'd0
`define ALUC_SUB 2'd1
`define ALUC_FN  2'd2  // pick by function code

`endif

// ==== testbench/tb_chip_top.sv ====
// testbench for the pipelined processor checking directed programs through its store stream
`timescale 1ns/10ps
`default_nettype none
`include "chip_params.svh"

module tb_chip_top;
    import chip_pkg::*;

    localparam int PERIOD     = 40;
    localparam int PROG_WORDS = 5 * 45;              // all programs together
    localparam int WORST_FILL = 2 * (7 + 3);         // write-back plus refill in cycles
    localparam int WATCHDOG   = PROG_WORDS * WORST_FILL * 4 * PERIOD + 100 * PERIOD;
    localparam word_t VAL_A   = 32'hffff_fffb;       // -5
    localparam word_t VAL_B   = 32'h0000_0007;

    logic   clk, rst_n;
    logic   mem_read_i, mem_write_i, mem_ready_i, mem_read_d, mem_write_d, mem_ready_d;
    baddr_t mem_addr_i, mem_addr_d;
    line_t  mem_wdata_i, mem_rdata_i, mem_wdata_d, mem_rdata_d;
    waddr_t dcache_addr;
    word_t  dcache_wdata;
    logic   dcache_wen;

    int     errors;
    int     pc_ptr;
    waddr_t st_addr [$];
    word_t  st_data [$];
    waddr_t exp_addr [$];
    word_t  exp_data [$];
    logic   prev_wen;
    waddr_t prev_addr;
    word_t  prev_data;
    logic   wb_seen;
    baddr_t wb_addr;
    line_t  wb_line;

    chip_top DUT (.*);

    tb_mem_model imem (.clk(clk), .rst_n(rst_n), .mem_read(mem_read_i),
        .mem_write(mem_write_i), .mem_addr(mem_addr_i), .mem_wdata(mem_wdata_i),
        .mem_rdata(mem_rdata_i), .mem_ready(mem_ready_i));
    tb_mem_model dmem (.clk(clk), .rst_n(rst_n), .mem_read(mem_read_d),
        .mem_write(mem_write_d), .mem_addr(mem_addr_d), .mem_wdata(mem_wdata_d),
        .mem_rdata(mem_rdata_d), .mem_ready(mem_ready_d));

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // ------------------------------
    // monitors
    always @(negedge clk) begin
        if (!rst_n) begin
            prev_wen = 1'b0;
        end else begin
            if (dcache_wen && (!prev_wen || dcache_addr != prev_addr ||
                               dcache_wdata != prev_data)) begin
                st_addr.push_back(dcache_addr);
                st_data.push_back(dcache_wdata);
            end
            prev_wen  = dcache_wen;
            prev_addr = dcache_addr;
            prev_data = dcache_wdata;
            // instruction cache is read-only
            check_value("mem_write_i", 0, mem_write_i);
            check_value("mem_wdata_i", 0, mem_wdata_i);
        end
        if (mem_write_d && mem_ready_d && !wb_seen) begin  // first eviction only
            wb_seen = 1'b1;
            wb_addr = mem_addr_d;
            wb_line = mem_wdata_d;
        end
    end

    initial begin
        #(WATCHDOG);
        $display("watchdog expired, the run did not finish in time");
        $display("Test failures found");
        $finish;
    end

    // ------------------------------
    // helpers
    task automatic check_value(input string name, input logic [127:0] exp,
                               input logic [127:0] act);
        if (exp !== act) begin
            errors++;
            $display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    function automatic word_t fill_word(input int i);
        return 32'hd5a0_0000 ^ (i * 32'h0001_0081);
    endfunction

    function automatic word_t r_type(input int rs, input int rt, input int rd,
                                     input logic [5:0] fn);
        return {`OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic word_t i_type(input logic [5:0] op, input int rs, input int rt,
                                     input int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    task automatic emit(input word_t w);
        imem.mem[pc_ptr] = w;
        pc_ptr++;
    endtask

    task automatic emit_nops(input int n);
        repeat (n) emit('0);
    endtask

    task automatic expect_store(input int addr, input word_t data);
        exp_addr.push_back(waddr_t'(addr));
        exp_data.push_back(data);
    endtask

    // clears both memories and the expectations before a new program
    task automatic new_program;
        for (int i = 0; i < 1024; i++) begin
            imem.mem[i] = '0;
            dmem.mem[i] = fill_word(i);
        end
        dmem.mem[16] = VAL_A;
        dmem.mem[17] = VAL_B;
        pc_ptr = 0;
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic finish_program;
        emit(i_type(`OP_BEQ, 0, 0, -1));  // spin here
        emit_nops(4);
    endtask

    task automatic apply_reset;
        @(posedge clk);
        #2;
        rst_n = 1'b0;
        st_addr.delete();
        st_data.delete();
        wb_seen = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
    endtask

    // waits for the expected stores and compares them in order
    task automatic check_stores(input string tag);
        int cycles;
        cycles = 0;
        while (st_addr.size() < exp_addr.size() && cycles < 5000) begin
            @(posedge clk);
            cycles++;
        end
        if (st_addr.size() < exp_addr.size()) begin
            errors++;
            $display("%s: only %0d of %0d stores seen before timeout", tag, st_addr.size(),
                     exp_addr.size());
        end else begin
            foreach (exp_addr[i]) begin
                check_value($sformatf("%s dcache_addr[%0d]", tag, i), exp_addr[i], st_addr[i]);
                check_value($sformatf("%s dcache_wdata[%0d]", tag, i), exp_data[i], st_data[i]);
            end
        end
    endtask

    // ------------------------------
    // directed tests
    task automatic test_reset_idle;
        int cycles;
        new_program();
        finish_program();
        apply_reset();
        check_value("mem_read_i", 0, mem_read_i);
        check_value("mem_read_d", 0, mem_read_d);
        check_value("mem_write_d", 0, mem_write_d);
        check_value("mem_write_i", 0, mem_write_i);
        check_value("dcache_wen", 0, dcache_wen);
        cycles = 0;
        while (!mem_read_i && cycles < 20) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!mem_read_i) begin
            errors++;
            $display("instruction memory read never started after reset");
        end
        check_value("mem_addr_i", 0, mem_addr_i);
        check_value("mem_read_d", 0, mem_read_d);
        check_value("dcache_wen", 0, dcache_wen);
    endtask

    task automatic test_alu(input string tag);
        new_program();
        emit(i_type(`OP_LW, 0, 1, 16));
        emit(i_type(`OP_LW, 0, 2, 17));
        emit_nops(4);
        emit(r_type(1, 2, 3, `FN_ADD));
        emit(r_type(1, 2, 4, `FN_SUB));
        emit(r_type(1, 2, 5, `FN_AND));
        emit(r_type(1, 2, 6, `FN_OR));
        emit(r_type(1, 2, 7, `FN_SLT));
        emit(r_type(2, 1, 8, `FN_SLT));
        emit_nops(4);
        for (int r = 3; r <= 8; r++) begin
            emit(i_type(`OP_SW, 0, r, 29 + r));
        end
        finish_program();
        expect_store(32, VAL_A + VAL_B);
        expect_store(33, VAL_A - VAL_B);
        expect_store(34, VAL_A & VAL_B);
        expect_store(35, VAL_A | VAL_B);
        expect_store(36, 32'd1);  // -5 < 7 when signed
        expect_store(37, 32'd0);  // 7 < -5 is false
        apply_reset();
        check_stores(tag);
    endtask

    task automatic test_branch(input bit taken);
        new_program();
        emit(i_type(`OP_LW, 0, 1, 16));
        emit_nops(4);
        emit(i_type(`OP_BEQ, 0, taken ? 0 : 1, 5));  // target skips two stores
        for (int k = 0; k < 6; k++) begin
            emit(i_type(`OP_SW, 0, 1, 40 + k));
            if (!taken || k < 3 || k == 5) begin
                expect_store(40 + k, VAL_A);
            end
        end
        finish_program();
        apply_reset();
        check_stores(taken ? "beq taken" : "beq not taken");
    endtask

    task automatic test_evict;
        line_t exp_line;
        new_program();
        emit(i_type(`OP_LW, 0, 1, 16));
        emit(i_type(`OP_LW, 0, 2, 17));
        emit_nops(4);
        emit(i_type(`OP_SW, 0, 1, 8));   // index 2 with tag 0
        emit(i_type(`OP_SW, 0, 2, 40));  // index 2 with tag 1 evicts the line above
        emit(i_type(`OP_LW, 0, 3, 8));
        emit_nops(4);
        emit(i_type(`OP_SW, 0, 3, 50));
        finish_program();
        expect_store(8, VAL_A);
        expect_store(40, VAL_B);
        expect_store(50, VAL_A);
        exp_line = {fill_word(11), fill_word(10), fill_word(9), VAL_A};
        apply_reset();
        check_stores("eviction");
        if (!wb_seen) begin
            errors++;
            $display("no write-back of the dirty line was seen");
        end else begin
            check_value("mem_addr_d", 28'd2, wb_addr);
            check_value("mem_wdata_d", exp_line, wb_line);
        end
    endtask

    initial begin
        rst_n  = 1'b0;
        errors = 0;
        test_reset_idle();
        test_alu("alu");
        test_branch(1'b1);
        test_branch(1'b0);
        test_evict();
        imem.rand_en = 1'b1;  // random ready delays from here on
        dmem.rand_en = 1'b1;
        test_alu("alu random delay");
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_mem_model.sv ====
// memory model: line-wide word memory answering cache refills and write-backs
`timescale 1ns/10ps
`default_nettype none
`include "chip_params.svh"

module tb_mem_model #(
    parameter int          DEPTH = 1024,  // words
    parameter logic [31:0] SEED  = 32'he892
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             mem_read,
    input  logic             mem_write,
    input  chip_pkg::baddr_t mem_addr,
    input  chip_pkg::line_t  mem_wdata,
    output chip_pkg::line_t  mem_rdata,
    output logic             mem_ready
);
    import chip_pkg::*;

    localparam int MAX_DELAY = 7;

    word_t       mem [0:DEPTH-1];
    logic        rand_en;  // random ready delay when set
    logic [31:0] lcg_state;
    int          delay;
    int          base;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    initial begin
        mem_ready = 1'b0;
        mem_rdata = '0;
        rand_en   = 1'b0;
        lcg_state = SEED;
        forever begin
            @(posedge clk);
            #1;
            if (rst_n && (mem_read || mem_write)) begin
                delay = 0;
                if (rand_en) begin
                    lcg_state = lcg_next(lcg_state);
                    delay = int'((lcg_state >> 16) % (MAX_DELAY + 1));
                end
                repeat (delay + 1) @(posedge clk);
                #2;
                base = int'(mem_addr % (DEPTH / 4)) * 4;
                for (int k = 0; k < 4; k++) begin
                    if (mem_write) begin
                        mem[base + k] = mem_wdata[k*32 +: 32];
                    end else begin
                        mem_rdata[k*32 +: 32] = mem[base + k];  // word k at offset k
                    end
                end
                mem_ready = 1'b1;  // one-cycle pulse
                @(posedge clk);
                #2;
                mem_ready = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire
